/* logic/isa_pkg.sv */
// RISC-V fetch-time ISA definitions
package isa_pkg;

	// machine width and raw instruction width
	localparam int XLEN = 64;
	localparam int ILEN = 32;

	typedef logic [XLEN-1:0] addr_t;
	typedef logic [ILEN-1:0] insn_t;

	// major opcode field sits in the low bits of every encoding
	localparam int OPC_W = 7;

	typedef logic [OPC_W-1:0] opcode_t;

	localparam opcode_t OPC_JAL    = 7'b1101111;
	localparam opcode_t OPC_BRANCH = 7'b1100011;

	// addi x0, x0, 0
	localparam insn_t NOP_INSN = 32'h0000_0013;

	// sequential PC step, no compressed encodings
	localparam addr_t INSN_BYTES = 64'd4;

	// instruction bit 31 is the sign of every immediate format
	localparam int INSN_SIGN_BIT = 31;

	// assembled immediate widths, bit 0 always zero
	localparam int J_IMM_W = 21;
	localparam int B_IMM_W = 13;

	typedef logic [J_IMM_W-1:0] j_imm_t;
	typedef logic [B_IMM_W-1:0] b_imm_t;

	// J-type: imm[20|10:1|11|19:12] in insn[31:12]
	// B-type: imm[12|10:5] in insn[31:25], imm[4:1|11] in insn[11:7]

endpackage

/* logic/frontend_pkg.sv */
// fetch front end configuration
package frontend_pkg;

	import isa_pkg::*;

	// fetch buffer geometry
	localparam int IFB_DEPTH = 8;
	localparam int IFB_PTR_W = $clog2(IFB_DEPTH);

	typedef logic [IFB_PTR_W-1:0] ifb_ptr_t;

	// pointer plus its wrap bit, wrap bit on top
	typedef logic [IFB_PTR_W:0] ifb_ptr_wrap_t;

	// last slot, pointers roll over to zero after it
	localparam ifb_ptr_t IFB_LAST = ifb_ptr_t'(IFB_DEPTH - 1);

	// first fetch address after reset
	localparam addr_t RESET_PC = 64'h0000_0000_0000_1000;

	// PC generator states
	typedef enum logic {
		FETCH_IDLE,
		FETCH_RUN
	} fetch_state_e;

endpackage

/* logic/fetch_entry_if.sv */
// fetched entry bus
`timescale 1ns/1ps

interface fetch_entry_if
	import isa_pkg::*;
();

	// push strobe, one entry per cycle while high
	logic valid;
	insn_t insn;
	addr_t pc;
	// PC the generator moved to after this entry
	addr_t pred_target;

	modport producer (
		output valid,
		output insn,
		output pc,
		output pred_target
	);

	modport consumer (
		input valid,
		input insn,
		input pc,
		input pred_target
	);

endinterface

/* logic/pc_gen.sv */
// PC generator with static prediction
`timescale 1ns/1ps

module pc_gen
	import isa_pkg::*;
	import frontend_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            redirect_valid_i,
	input  addr_t           redirect_pc_i,
	input  logic            ifb_full_i,
	input  insn_t           imem_data_i,
	output addr_t           imem_addr_o,
	fetch_entry_if.producer entry_o
);

	fetch_state_e state_q;
	fetch_state_e state_d;
	addr_t        pc_q;
	addr_t        pc_d;
	logic         fetch_en;

	// fetch-time decode
	opcode_t opcode;
	logic    is_jal;
	logic    is_branch;
	logic    branch_back;
	j_imm_t  j_imm;
	b_imm_t  b_imm;
	addr_t   j_offset;
	addr_t   b_offset;

	// candidate next PCs
	addr_t seq_pc;
	addr_t jal_target;
	addr_t br_target;
	addr_t pred_target;

	// memory is combinational, the word at pc_q is back this cycle
	assign imem_addr_o = pc_q;

	assign opcode      = imem_data_i[OPC_W-1:0];
	assign is_jal      = (opcode == OPC_JAL);
	assign is_branch   = (opcode == OPC_BRANCH);
	// negative offset means a loop, predict taken
	assign branch_back = imem_data_i[INSN_SIGN_BIT];

	// reassemble the scattered immediate bits
	assign j_imm = {imem_data_i[31], imem_data_i[19:12], imem_data_i[20],
		imem_data_i[30:21], 1'b0};
	assign b_imm = {imem_data_i[31], imem_data_i[7], imem_data_i[30:25],
		imem_data_i[11:8], 1'b0};

	// sign extend to full address width
	assign j_offset = {{(XLEN-J_IMM_W){j_imm[J_IMM_W-1]}}, j_imm};
	assign b_offset = {{(XLEN-B_IMM_W){b_imm[B_IMM_W-1]}}, b_imm};

	assign seq_pc     = pc_q + INSN_BYTES;
	assign jal_target = pc_q + j_offset;
	assign br_target  = pc_q + b_offset;

	always_comb begin
		if (is_jal) begin
			pred_target = jal_target;
		end else if (is_branch && branch_back) begin
			pred_target = br_target;
		end else begin
			pred_target = seq_pc;
		end
	end

	// no push on a redirect cycle or while the buffer is full
	assign fetch_en = (state_q == FETCH_RUN) && !ifb_full_i && !redirect_valid_i;

	always_comb begin
		state_d = state_q;
		case (state_q)
			// one quiet cycle out of reset
			FETCH_IDLE: state_d = FETCH_RUN;
			FETCH_RUN:  state_d = FETCH_RUN;
			default:    state_d = FETCH_IDLE;
		endcase
	end

	// redirect wins over the predicted path, otherwise hold under back-pressure
	always_comb begin
		if (redirect_valid_i) begin
			pc_d = redirect_pc_i;
		end else if (fetch_en) begin
			pc_d = pred_target;
		end else begin
			pc_d = pc_q;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= FETCH_IDLE;
			pc_q    <= RESET_PC;
		end else begin
			state_q <= state_d;
			pc_q    <= pc_d;
		end
	end

	assign entry_o.valid       = fetch_en;
	assign entry_o.insn        = imem_data_i;
	assign entry_o.pc          = pc_q;
	assign entry_o.pred_target = pred_target;

endmodule

/* logic/insn_fetch_buffer.sv */
// instruction fetch buffer
`timescale 1ns/1ps

module insn_fetch_buffer
	import isa_pkg::*;
	import frontend_pkg::*;
(
	input  logic            clk,
	input  logic            rst,
	input  logic            flush_i,
	input  logic            pop_i,
	fetch_entry_if.consumer entry_i,
	output logic            full_o,
	output logic            empty_o,
	output insn_t           insn_o,
	output addr_t           pc_o,
	output addr_t           pred_target_o
);

	// entry storage, one slot per buffer position
	insn_t insn_mem [IFB_DEPTH];
	addr_t pc_mem   [IFB_DEPTH];
	addr_t tgt_mem  [IFB_DEPTH];

	ifb_ptr_t head_q;
	ifb_ptr_t tail_q;
	logic     head_wrap_q;
	logic     tail_wrap_q;
	ifb_ptr_t head_d;
	ifb_ptr_t tail_d;
	logic     head_wrap_d;
	logic     tail_wrap_d;

	logic push;
	logic pop_ok;

	// advance a pointer, flipping its wrap bit when it rolls over
	function automatic ifb_ptr_wrap_t step_ptr(input logic wrap, input ifb_ptr_t ptr);
		ifb_ptr_wrap_t next;
		if (ptr == IFB_LAST) begin
			next = {~wrap, ifb_ptr_t'(0)};
		end else begin
			next = {wrap, ifb_ptr_t'(ptr + 1'b1)};
		end
		return next;
	endfunction

	// same index, wrap bits tell empty from full
	assign empty_o = (head_q == tail_q) && (head_wrap_q == tail_wrap_q);
	assign full_o  = (head_q == tail_q) && (head_wrap_q != tail_wrap_q);

	// producer already holds off when full
	assign push   = entry_i.valid;
	// a pop on an empty buffer leaves the head alone
	assign pop_ok = pop_i && !empty_o;

	always_comb begin
		if (pop_ok) begin
			{head_wrap_d, head_d} = step_ptr(head_wrap_q, head_q);
		end else begin
			{head_wrap_d, head_d} = {head_wrap_q, head_q};
		end
		if (push) begin
			{tail_wrap_d, tail_d} = step_ptr(tail_wrap_q, tail_q);
		end else begin
			{tail_wrap_d, tail_d} = {tail_wrap_q, tail_q};
		end
	end

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			head_q      <= '0;
			tail_q      <= '0;
			head_wrap_q <= 1'b0;
			tail_wrap_q <= 1'b0;
		end else begin
			head_q      <= head_d;
			tail_q      <= tail_d;
			head_wrap_q <= head_wrap_d;
			tail_wrap_q <= tail_wrap_d;
		end
	end

	// flush also wipes the slots so stale entries never reach decode
	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			for (int i = 0; i < IFB_DEPTH; i++) begin
				insn_mem[i] <= '0;
				pc_mem[i]   <= '0;
				tgt_mem[i]  <= '0;
			end
		end else if (push) begin
			insn_mem[tail_q] <= entry_i.insn;
			pc_mem[tail_q]   <= entry_i.pc;
			tgt_mem[tail_q]  <= entry_i.pred_target;
		end
	end

	// head entry shows only while decode strobes a pop
	assign insn_o        = pop_i ? insn_mem[head_q] : '0;
	assign pc_o          = pop_i ? pc_mem[head_q] : '0;
	assign pred_target_o = pop_i ? tgt_mem[head_q] : '0;

endmodule

/* logic/fetch_frontend.sv */
// instruction fetch front end
`timescale 1ns/1ps

module fetch_frontend
	import isa_pkg::*;
(
	input  logic  clk,
	input  logic  rst,

	// back end redirect
	input  logic  redirect_valid_i,
	input  addr_t redirect_pc_i,

	// decode side
	input  logic  decode_pop_i,
	output logic  ifb_empty_o,
	output insn_t insn_o,
	output addr_t pc_o,
	output addr_t pred_target_o,

	// instruction memory port
	input  insn_t imem_data_i,
	output addr_t imem_addr_o
);

	logic ifb_full;

	fetch_entry_if entry_bus ();

	pc_gen pc_gen_inst (
		.clk              (clk),
		.rst              (rst),
		.redirect_valid_i (redirect_valid_i),
		.redirect_pc_i    (redirect_pc_i),
		.ifb_full_i       (ifb_full),
		.imem_data_i      (imem_data_i),
		.imem_addr_o      (imem_addr_o),
		.entry_o          (entry_bus.producer)
	);

	// redirect doubles as the buffer flush
	insn_fetch_buffer insn_fetch_buffer_inst (
		.clk           (clk),
		.rst           (rst),
		.flush_i       (redirect_valid_i),
		.pop_i         (decode_pop_i),
		.entry_i       (entry_bus.consumer),
		.full_o        (ifb_full),
		.empty_o       (ifb_empty_o),
		.insn_o        (insn_o),
		.pc_o          (pc_o),
		.pred_target_o (pred_target_o)
	);

endmodule

/* dv/fetch_frontend_asserts.sv */
// fetch buffer invariant checks
`timescale 1ns/1ps

module fetch_frontend_asserts
	import frontend_pkg::*;
(
	input logic     clk,
	input logic     rst,
	input logic     flush_i,
	input logic     push_i,
	input logic     pop_i,
	input logic     full_i,
	input logic     empty_i,
	input ifb_ptr_t head_i,
	input logic     head_wrap_i
);

	// entry count built from the strobes alone
	logic [IFB_PTR_W:0] occupancy;
	logic               pop_taken;

	assign pop_taken = pop_i && (occupancy != '0);

	always_ff @(posedge clk) begin
		if (rst || flush_i) begin
			occupancy <= '0;
		end else if (push_i && !pop_taken) begin
			occupancy <= occupancy + 1'b1;
		end else if (pop_taken && !push_i) begin
			occupancy <= occupancy - 1'b1;
		end
	end

	// flags track the count and so are never set together
	full_empty_excl: assert property (@(posedge clk) disable iff (rst)
		(empty_i == (occupancy == '0)) && (full_i == (occupancy == IFB_DEPTH)))
		else $error("full or empty flag disagrees with the entry count");

	// producer holds off while the buffer is full
	no_push_when_full: assert property (@(posedge clk) disable iff (rst)
		!(push_i && full_i))
		else $error("push into a full buffer");

	// empty pop leaves head and wrap bit alone
	head_holds_on_empty_pop: assert property (@(posedge clk) disable iff (rst)
		(pop_i && empty_i && !flush_i) |=>
			(head_i == $past(head_i) && head_wrap_i == $past(head_wrap_i)))
		else $error("head moved on a pop from an empty buffer");

endmodule

bind insn_fetch_buffer fetch_frontend_asserts asserts_inst (
	.clk         (clk),
	.rst         (rst),
	.flush_i     (flush_i),
	.push_i      (push),
	.pop_i       (pop_i),
	.full_i      (full_o),
	.empty_i     (empty_o),
	.head_i      (head_q),
	.head_wrap_i (head_wrap_q)
);

/* dv/fetch_frontend_tb.sv */
// fetch front end testbench
`timescale 1ns/1ps

module fetch_frontend_tb
	import isa_pkg::*;
	import frontend_pkg::*;
();

	localparam int CLK_PERIOD = 100;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS = 6;
	localparam int WATCHDOG_NS = (NUM_TESTS * 200 + RESET_CYCLES) * CLK_PERIOD;

	logic  clk;
	logic  rst;
	logic  redirect_valid;
	addr_t redirect_pc;
	logic  decode_pop;
	insn_t imem_data = NOP_INSN;
	addr_t imem_addr;
	logic  ifb_empty;
	insn_t insn_out;
	addr_t pc_out;
	addr_t tgt_out;

	// program model, bumping prog_gen makes the memory answer again
	insn_t prog [addr_t];
	int    prog_gen;
	// expected stream and what decode actually got
	addr_t exp_pc [$];
	insn_t exp_insn [$];
	addr_t exp_tgt [$];
	addr_t got_pc [$];
	addr_t got_tgt [$];

	int          errors;
	int          checks;
	int          tests_run;
	int          tests_failed;
	logic [31:0] rng;

	fetch_frontend fetch_frontend_inst (
		.clk              (clk),
		.rst              (rst),
		.redirect_valid_i (redirect_valid),
		.redirect_pc_i    (redirect_pc),
		.decode_pop_i     (decode_pop),
		.ifb_empty_o      (ifb_empty),
		.insn_o           (insn_out),
		.pc_o             (pc_out),
		.pred_target_o    (tgt_out),
		.imem_data_i      (imem_data),
		.imem_addr_o      (imem_addr)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic insn_t read_word(input addr_t addr);
		if (prog.exists(addr)) begin
			return prog[addr];
		end
		return NOP_INSN;
	endfunction

	always @(imem_addr or prog_gen) begin
		imem_data = read_word(imem_addr);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		return s ^ (s << 5);
	endfunction

	function automatic insn_t jal_insn(input int offset);
		logic [20:0] imm;
		imm = offset[20:0];
		// jal x1
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, OPC_JAL};
	endfunction

	function automatic insn_t branch_insn(input int offset);
		logic [12:0] imm;
		imm = offset[12:0];
		// beq x1, x2
		return {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], OPC_BRANCH};
	endfunction

	// static rule: jal taken, backward branch taken, else fall through
	function automatic addr_t next_pc_ref(input addr_t pc, input insn_t w);
		logic signed [20:0] j_off;
		logic signed [12:0] b_off;
		j_off = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		b_off = {w[31], w[7], w[30:25], w[11:8], 1'b0};
		if (w[6:0] == OPC_JAL) begin
			return pc + 64'(j_off);
		end else if (w[6:0] == OPC_BRANCH && b_off < 0) begin
			return pc + 64'(b_off);
		end
		return pc + INSN_BYTES;
	endfunction

	task automatic build_ref(input addr_t start, input int n);
		addr_t pc;
		insn_t w;
		exp_pc.delete();
		exp_insn.delete();
		exp_tgt.delete();
		pc = start;
		repeat (n) begin
			w = read_word(pc);
			exp_pc.push_back(pc);
			exp_insn.push_back(w);
			exp_tgt.push_back(next_pc_ref(pc, w));
			pc = next_pc_ref(pc, w);
		end
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_entry(input int idx);
		check_value("pc_o", pc_out, exp_pc[idx]);
		check_value("insn_o", 64'(insn_out), 64'(exp_insn[idx]));
		check_value("pred_target_o", tgt_out, exp_tgt[idx]);
	endtask

	// entered at a falling edge, leaves the pop strobe high at the next one
	task automatic pop_entry(input int idx);
		while (ifb_empty) begin
			decode_pop = 1'b0;
			@(negedge clk);
		end
		decode_pop = 1'b1;
		#(CLK_PERIOD / 4);
		compare_entry(idx);
		got_pc.push_back(pc_out);
		got_tgt.push_back(tgt_out);
		@(negedge clk);
	endtask

	// pops n entries and checks that each one follows the previous prediction
	task automatic pop_and_compare(input int n, input int first);
		int base;
		base = got_pc.size();
		for (int i = 0; i < n; i++) begin
			pop_entry(first + i);
		end
		for (int i = (base > 0) ? base : 1; i < got_pc.size(); i++) begin
			check_value("pc_o after pred_target", got_pc[i], got_tgt[i-1]);
		end
	endtask

	task automatic check_target(input addr_t at_pc, input addr_t exp_tgt_pc);
		int hits;
		hits = 0;
		foreach (got_pc[i]) begin
			if (got_pc[i] == at_pc) begin
				check_value("pred_target_o", got_tgt[i], exp_tgt_pc);
				hits++;
			end
		end
		checks++;
		assert (hits > 0) else begin
			$display("ERROR t=%0t instruction at %h was never popped", $time, at_pc);
			errors++;
		end
	endtask

	task automatic restart(input addr_t pc);
		decode_pop = 1'b0;
		redirect_valid = 1'b1;
		redirect_pc = pc;
		@(negedge clk);
		redirect_valid = 1'b0;
		redirect_pc = '0;
		checks++;
		assert (ifb_empty) else begin
			$display("ERROR t=%0t buffer still holds entries after a redirect", $time);
			errors++;
		end
		got_pc.delete();
		got_tgt.delete();
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_straight_line();
		int e0;
		e0 = errors;
		build_ref(RESET_PC, 24);
		pop_and_compare(24, 0);
		decode_pop = 1'b0;
		report_test("straight_line", e0);
	endtask

	task automatic test_back_pressure();
		int e0;
		e0 = errors;
		restart(64'h5000);
		build_ref(64'h5000, 40);
		pop_and_compare(5, 0);
		decode_pop = 1'b0;
		repeat (30) @(negedge clk);
		// a full buffer stalls fetch on the next unbuffered word
		check_value("imem_addr_o", imem_addr, exp_pc[5 + IFB_DEPTH]);
		pop_and_compare(20, 5);
		decode_pop = 1'b0;
		report_test("back_pressure", e0);
	endtask

	task automatic test_jal();
		int e0;
		e0 = errors;
		prog.delete();
		prog[64'h2004] = jal_insn(32'h40);
		prog[64'h2048] = jal_insn(-32'h44);
		prog_gen++;
		restart(64'h2000);
		build_ref(64'h2000, 12);
		pop_and_compare(12, 0);
		decode_pop = 1'b0;
		check_target(64'h2004, 64'h2044);
		check_target(64'h2048, 64'h2004);
		report_test("jal", e0);
	endtask

	task automatic test_branches();
		int e0;
		e0 = errors;
		prog.delete();
		prog[64'h3000] = branch_insn(32'h20);
		prog[64'h300c] = branch_insn(-32'h8);
		prog_gen++;
		restart(64'h3000);
		build_ref(64'h3000, 12);
		pop_and_compare(12, 0);
		decode_pop = 1'b0;
		check_target(64'h3000, 64'h3004);
		check_target(64'h300c, 64'h3004);
		report_test("branches", e0);
	endtask

	task automatic test_redirect();
		int  e0;
		bit  old_pc [addr_t];
		e0 = errors;
		prog.delete();
		prog_gen++;
		restart(64'h7000);
		build_ref(64'h7000, 30);
		foreach (exp_pc[i]) begin
			old_pc[exp_pc[i]] = 1'b1;
		end
		pop_and_compare(6, 0);
		// buffer is partly filled when the back end steers away
		restart(64'h9000);
		build_ref(64'h9000, 12);
		pop_and_compare(12, 0);
		decode_pop = 1'b0;
		check_value("first pc_o", got_pc[0], 64'h9000);
		foreach (got_pc[i]) begin
			checks++;
			assert (!old_pc.exists(got_pc[i])) else begin
				$display("ERROR t=%0t stale pc %h popped after redirect", $time, got_pc[i]);
				errors++;
			end
		end
		report_test("redirect", e0);
	endtask

	task automatic test_random_pop();
		int e0;
		int k;
		e0 = errors;
		k = 0;
		prog.delete();
		prog[64'h4004] = branch_insn(32'h10);
		prog[64'h4008] = jal_insn(32'h20);
		prog[64'h402c] = branch_insn(-32'h1c);
		prog[64'h4014] = jal_insn(32'h100);
		prog[64'h4118] = branch_insn(-32'h118);
		prog_gen++;
		restart(64'h4000);
		build_ref(64'h4000, 150);
		repeat (140) begin
			rng = xorshift32(rng);
			decode_pop = rng[0];
			#(CLK_PERIOD / 4);
			if (decode_pop && !ifb_empty) begin
				compare_entry(k);
				k++;
			end else if (!decode_pop) begin
				check_value("idle pc_o", pc_out, 64'd0);
				check_value("idle insn_o", 64'(insn_out), 64'd0);
				check_value("idle pred_target_o", tgt_out, 64'd0);
			end
			@(negedge clk);
		end
		decode_pop = 1'b0;
		checks++;
		assert (k > 0) else begin
			$display("ERROR t=%0t no entry was popped in the random run", $time);
			errors++;
		end
		report_test("random_pop", e0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR watchdog expired after %0d ns", WATCHDOG_NS);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	initial begin
		rst = 1'b1;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		decode_pop = 1'b0;
		prog_gen = 0;
		errors = 0;
		checks = 0;
		tests_run = 0;
		tests_failed = 0;
		rng = 32'd570;
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;
		test_straight_line();
		test_back_pressure();
		test_jal();
		test_branches();
		test_redirect();
		test_random_pop();
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* fetch_frontend.f */
logic/isa_pkg.sv
logic/frontend_pkg.sv
logic/fetch_entry_if.sv
logic/pc_gen.sv
logic/insn_fetch_buffer.sv
logic/fetch_frontend.sv
dv/fetch_frontend_asserts.sv
dv/fetch_frontend_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the fetch front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module fetch_frontend_tb \
	-f fetch_frontend.f \
	-Mdir obj_dir -o fetch_frontend_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/fetch_frontend_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
	exit 1
fi
if ! grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "no result line in $LOG"
	exit 1
fi
exit 0
